//--- filelist.f
+incdir+source
source/uart_pkg.sv
source/mem_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/ascii_cmd_decoder.sv
source/mem_controller.sv
source/debug_led_regs.sv
source/uart_mem_top.sv
verif/uart_mem_assertions.sv
verif/tb_uart_mem.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the UART memory bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -Wno-fatal \
    --top-module tb_uart_mem \
    -f filelist.f

# a $fatal in the testbench gives a non-zero exit status here
./obj_dir/Vtb_uart_mem

//--- source/ascii_cmd_decoder.sv
`timescale 1ns/1ps

module ascii_cmd_decoder (
    input  logic                 i_controller_clk,
    input  logic                 i_rst,
    input  uart_pkg::uart_byte_t i_rx_byte,
    input  logic                 i_rx_valid,
    output logic                 o_rx_ready,
    input  logic                 i_stall,
    output mem_pkg::mem_req_t    o_req,
    output logic                 o_req_stb
);
    import mem_pkg::*;

    logic     is_lower;                    // 'a' to 'z'
    logic     is_upper;                    // 'A' to 'Z'
    logic     pend_valid;                  // one entry buffer holds a request
    mem_req_t new_req;

    assign o_rx_ready = 1'b1;              // bytes come far slower than requests drain

    always_comb begin
        is_lower = (i_rx_byte.data >= 8'd97) && (i_rx_byte.data <= 8'd122);
        is_upper = (i_rx_byte.data >= 8'd65) && (i_rx_byte.data <= 8'd90);
        if (is_lower) begin                // write the letter itself
            new_req.op   = op_write;
            new_req.addr = ~i_rx_byte.data;
            new_req.data = i_rx_byte.data;
        end else begin                     // read from lowercase slot
            new_req.op   = op_read;
            new_req.addr = ~(i_rx_byte.data + 8'd32);
            new_req.data = 8'h00;
        end
    end

    // strobe only while stall is low, so a strobe is always an accept
    assign o_req_stb = pend_valid && !i_stall;

    always_ff @(posedge i_controller_clk) begin
        if (!i_rst) begin
            pend_valid <= 1'b0;
        end else if (i_rx_valid && (is_lower || is_upper)) begin
            pend_valid <= 1'b1;            // new letter, other bytes dropped
        end else if (o_req_stb) begin
            pend_valid <= 1'b0;            // accepted
        end
    end

    always_ff @(posedge i_controller_clk) begin
        if (i_rx_valid && (is_lower || is_upper)) o_req <= new_req;
    end

endmodule

//--- source/bridge_config.svh
`ifndef BRIDGE_CONFIG_SVH
`define BRIDGE_CONFIG_SVH

// serial line timing, all counts in i_controller_clk cycles

`define BRIDGE_UART_CLKS_PER_BIT 16       // short bit period for sim, board needs a real prescale

// memory model timing

`define BRIDGE_MEM_LATENCY 4              // accept to ack, also pipeline depth
`define BRIDGE_REFRESH_INTERVAL 200       // cycles between refresh requests
`define BRIDGE_REFRESH_CYCLES 6           // stall length once pipeline is empty

// derived widths are worked out with $clog2 inside each module,
// so changing a value here is enough

`endif

//--- source/debug_led_regs.sv
`timescale 1ns/1ps

module debug_led_regs (
    input  logic              i_controller_clk,
    input  logic              i_rst,
    input  logic [3:0]        i_btn,
    input  logic              i_req_accept,
    input  mem_pkg::mem_rsp_t i_rsp,
    input  logic              i_rsp_fire,
    output logic [7:0]        o_led
);

    logic [3:0]  btn_meta;                 // buttons are asynchronous
    logic [3:0]  btn_sync;
    logic [24:0] heartbeat;                // top bits blink slowly on the board
    logic [7:0]  req_count;                // accepted requests, wraps
    logic [7:0]  last_rsp;                 // byte of the latest ack sent
    logic        act_latch;                // request seen while button 1 held

    always_ff @(posedge i_controller_clk) begin
        if (!i_rst) begin
            btn_meta  <= '0;
            btn_sync  <= '0;
            heartbeat <= '0;
            req_count <= '0;
            last_rsp  <= '0;
            act_latch <= 1'b0;
        end else begin
            btn_meta  <= i_btn;
            btn_sync  <= btn_meta;
            heartbeat <= heartbeat + 1'b1;
            if (i_req_accept) req_count <= req_count + 1'b1;
            if (i_rsp_fire) last_rsp <= i_rsp.data;
            if (!btn_sync[1]) act_latch <= 1'b0;     // release clears it
            else if (i_req_accept) act_latch <= 1'b1;
        end
    end

    always_comb begin
        if (btn_sync[0]) o_led = {heartbeat[24:23], req_count[4:0], act_latch};
        else if (btn_sync[2]) o_led = req_count;
        else o_led = last_rsp;             // default view
    end

endmodule

//--- source/mem_controller.sv
`timescale 1ns/1ps
`include "bridge_config.svh"

module mem_controller (
    input  logic              i_controller_clk,
    input  logic              i_rst,
    input  mem_pkg::mem_req_t i_req,
    input  logic              i_req_stb,
    output logic              o_stall,
    output mem_pkg::mem_rsp_t o_rsp,
    output logic              o_rsp_valid,
    input  logic              i_rsp_ready
);
    import mem_pkg::*;

    localparam int LAT     = `BRIDGE_MEM_LATENCY;
    localparam int REF_INT = `BRIDGE_REFRESH_INTERVAL;
    localparam int REF_LEN = `BRIDGE_REFRESH_CYCLES;
    localparam int TW      = $clog2(REF_INT);
    localparam int LW      = $clog2(REF_LEN + 1);

    logic [7:0]     storage [256];         // word memory, one byte per address
    logic [LAT-1:0] pipe_valid;            // stage LAT-1 is the ack
    mem_rsp_t       pipe_rsp [LAT];        // response fields per stage
    mem_rsp_t       rd_rsp;                // stage 0 input
    ctrl_state_e    state;
    logic [TW-1:0]  ref_timer;             // free running refresh period
    logic [LW-1:0]  ref_cnt;               // pause cycles left
    logic           ref_due;               // refresh waiting for drain
    logic           freeze;                // ack held by the serial side
    logic           drained;
    logic           accept;

    assign freeze  = pipe_valid[LAT-1] && !i_rsp_ready;
    assign drained = (pipe_valid == '0);
    assign o_stall = freeze || ref_due || (state == refresh); // ref_due stops new work
    assign accept  = i_req_stb && !o_stall;

    assign o_rsp       = pipe_rsp[LAT-1];
    assign o_rsp_valid = pipe_valid[LAT-1];

    always_comb begin
        rd_rsp.op   = i_req.op;
        rd_rsp.data = (i_req.op == op_write) ? i_req.data : storage[i_req.addr]; // echo write
    end

    always_ff @(posedge i_controller_clk) begin
        if (!i_rst) begin
            for (int i = 0; i < 256; i++) storage[i] <= 8'h00; // cleared model storage
        end else if (accept && (i_req.op == op_write)) begin
            storage[i_req.addr] <= i_req.data;
        end
    end

    always_ff @(posedge i_controller_clk) begin
        if (!i_rst) begin
            pipe_valid <= '0;
        end else if (!freeze) begin
            pipe_valid <= {pipe_valid[LAT-2:0], accept}; // whole pipe moves or none
        end
    end

    always_ff @(posedge i_controller_clk) begin
        if (!freeze) begin
            pipe_rsp[0] <= rd_rsp;
            for (int i = 1; i < LAT; i++) pipe_rsp[i] <= pipe_rsp[i-1];
        end
    end

    always_ff @(posedge i_controller_clk) begin
        if (!i_rst) begin
            state     <= run;
            ref_timer <= '0;
            ref_cnt   <= '0;
            ref_due   <= 1'b0;
        end else begin
            if (ref_timer == TW'(REF_INT - 1)) begin
                ref_timer <= '0;
                ref_due   <= 1'b1;         // ask for a pause
            end else begin
                ref_timer <= ref_timer + 1'b1;
            end
            case (state)
                run: begin
                    if (ref_due && drained) begin // nothing in flight
                        ref_due <= 1'b0;
                        ref_cnt <= LW'(REF_LEN - 1);
                        state   <= refresh;
                    end
                end
                refresh: begin
                    if (ref_cnt == '0) state <= run;
                    else ref_cnt <= ref_cnt - 1'b1;
                end
                default: state <= run;
            endcase
        end
    end

endmodule

//--- source/mem_pkg.sv
package mem_pkg;

    // request opcode, matches wishbone we
    typedef enum logic {
        op_read  = 1'b0,                   // we low
        op_write = 1'b1                    // we high
    } mem_op_e;

    // request channel payload, sent with stb
    typedef struct packed {
        mem_op_e    op;                    // read or write
        logic [7:0] addr;                  // word address
        logic [7:0] data;                  // write data, zero for reads
    } mem_req_t;

    // ack payload back to the serial side
    typedef struct packed {
        mem_op_e    op;                    // opcode of the acked request
        logic [7:0] data;                  // written byte or stored byte
    } mem_rsp_t;

    // controller top level state
    typedef enum logic {
        run     = 1'b0,                    // normal operation
        refresh = 1'b1                     // refresh pause, stall held high
    } ctrl_state_e;

endpackage

//--- source/uart_mem_top.sv
`timescale 1ns/1ps

module uart_mem_top (
    input  logic       i_controller_clk,
    input  logic       i_rst,
    input  logic       i_rx,
    output logic       o_tx,
    input  logic [3:0] i_btn,
    output logic [7:0] o_led
);
    import uart_pkg::*;
    import mem_pkg::*;

    uart_byte_t rx_byte;                   // receive stream
    logic       rx_valid;
    logic       rx_ready;
    mem_req_t   req;                       // request channel
    logic       req_stb;
    logic       stall;
    mem_rsp_t   rsp;                       // response stream
    logic       rsp_valid;
    logic       rsp_ready;
    logic       req_accept;
    logic       rsp_fire;

    assign req_accept = req_stb && !stall;
    assign rsp_fire   = rsp_valid && rsp_ready;

    uart_rx u_uart_rx (
        .i_controller_clk(i_controller_clk), .i_rst(i_rst), .i_rx(i_rx),
        .o_rx_byte(rx_byte), .o_rx_valid(rx_valid), .i_rx_ready(rx_ready)
    );

    ascii_cmd_decoder u_decoder (
        .i_controller_clk(i_controller_clk), .i_rst(i_rst),
        .i_rx_byte(rx_byte), .i_rx_valid(rx_valid), .o_rx_ready(rx_ready),
        .i_stall(stall), .o_req(req), .o_req_stb(req_stb)
    );

    mem_controller u_mem_controller (
        .i_controller_clk(i_controller_clk), .i_rst(i_rst),
        .i_req(req), .i_req_stb(req_stb), .o_stall(stall),
        .o_rsp(rsp), .o_rsp_valid(rsp_valid), .i_rsp_ready(rsp_ready)
    );

    uart_tx u_uart_tx (
        .i_controller_clk(i_controller_clk), .i_rst(i_rst),
        .i_rsp(rsp), .i_rsp_valid(rsp_valid), .o_rsp_ready(rsp_ready), .o_tx(o_tx)
    );

    debug_led_regs u_debug_leds (
        .i_controller_clk(i_controller_clk), .i_rst(i_rst), .i_btn(i_btn),
        .i_req_accept(req_accept), .i_rsp(rsp), .i_rsp_fire(rsp_fire), .o_led(o_led)
    );

endmodule

//--- source/uart_pkg.sv
package uart_pkg;

    // frame sequencer states, shared by rx and tx
    typedef enum logic [1:0] {
        idle  = 2'd0,                      // line high, waiting
        start = 2'd1,                      // start bit, low
        data  = 2'd2,                      // eight data bits, lsb first
        stop  = 2'd3                       // stop bit, high
    } uart_state_e;

    // one byte on a valid/ready stream
    typedef struct packed {
        logic [7:0] data;                  // received or sent byte
    } uart_byte_t;

endpackage

//--- source/uart_rx.sv
`timescale 1ns/1ps
`include "bridge_config.svh"

module uart_rx (
    input  logic               i_controller_clk,
    input  logic               i_rst,
    input  logic               i_rx,
    output uart_pkg::uart_byte_t o_rx_byte,
    output logic               o_rx_valid,
    input  logic               i_rx_ready
);
    import uart_pkg::*;

    localparam int CLKS = `BRIDGE_UART_CLKS_PER_BIT;
    localparam int CW   = $clog2(CLKS);

    logic          rx_meta;                // first sync flop
    logic          rx_sync;                // line in clock domain
    uart_state_e   state;
    logic [CW-1:0] clk_cnt;                // cycles within current bit
    logic [2:0]    bit_idx;                // data bit number
    logic [7:0]    shift;                  // bits collected lsb first

    always_ff @(posedge i_controller_clk) begin
        if (!i_rst) begin
            rx_meta <= 1'b1;               // idle line is high
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge i_controller_clk) begin
        if (!i_rst) begin
            state      <= idle;
            clk_cnt    <= '0;
            bit_idx    <= '0;
            o_rx_valid <= 1'b0;
        end else begin
            if (o_rx_valid && i_rx_ready) o_rx_valid <= 1'b0; // byte taken
            case (state)
                idle: begin
                    clk_cnt <= '0;
                    if (!rx_sync) state <= start; // falling edge seen
                end
                start: begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (clk_cnt == CW'(CLKS / 2 - 1)) begin // middle of start bit
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? idle : data; // glitch goes back
                    end
                end
                data: begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (clk_cnt == CW'(CLKS - 1)) begin // mid data bit
                        clk_cnt <= '0;
                        shift   <= {rx_sync, shift[7:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= stop;
                    end
                end
                stop: begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (clk_cnt == CW'(CLKS - 1)) begin // mid stop bit
                        state <= idle;
                        if (rx_sync) begin  // framing error drops the byte
                            o_rx_byte.data <= shift;
                            o_rx_valid     <= 1'b1;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

//--- source/uart_tx.sv
`timescale 1ns/1ps
`include "bridge_config.svh"

module uart_tx (
    input  logic             i_controller_clk,
    input  logic             i_rst,
    input  mem_pkg::mem_rsp_t i_rsp,
    input  logic             i_rsp_valid,
    output logic             o_rsp_ready,
    output logic             o_tx
);
    import uart_pkg::*;

    localparam int CLKS = `BRIDGE_UART_CLKS_PER_BIT;
    localparam int CW   = $clog2(CLKS);

    uart_state_e   state;
    logic [CW-1:0] clk_cnt;                // cycles within current bit
    logic [2:0]    bit_idx;                // data bit being sent
    logic [7:0]    shift;                  // remaining data bits

    assign o_rsp_ready = (state == idle);  // one frame at a time

    always_ff @(posedge i_controller_clk) begin
        if (!i_rst) begin
            state   <= idle;
            clk_cnt <= '0;
            bit_idx <= '0;
            o_tx    <= 1'b1;               // line idles high
        end else begin
            case (state)
                idle: begin
                    clk_cnt <= '0;
                    if (i_rsp_valid) begin // transfer, ready is high here
                        shift <= i_rsp.data;
                        o_tx  <= 1'b0;     // start bit next cycle
                        state <= start;
                    end
                end
                start: begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (clk_cnt == CW'(CLKS - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        o_tx    <= shift[0]; // lsb first
                        shift   <= shift >> 1;
                        state   <= data;
                    end
                end
                data: begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (clk_cnt == CW'(CLKS - 1)) begin
                        clk_cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            o_tx  <= 1'b1; // stop bit
                            state <= stop;
                        end else begin
                            o_tx    <= shift[0];
                            shift   <= shift >> 1;
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                stop: begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (clk_cnt == CW'(CLKS - 1)) state <= idle; // ready again
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

//--- verif/tb_uart_mem.sv
`timescale 1ns/1ps
`include "bridge_config.svh"

module tb_uart_mem;

    localparam int CLKS     = `BRIDGE_UART_CLKS_PER_BIT;
    localparam int FRAME    = 10 * CLKS;            // cycles per serial frame
    localparam int WAIT_MAX = 6 * FRAME;            // idle limit while a byte is owed
    localparam int NUM_RAND = 200;

    logic       i_controller_clk;
    logic       i_rst;
    logic       i_rx;
    logic       o_tx;
    logic [3:0] i_btn;
    logic [7:0] o_led;

    logic [7:0] model_mem [256];                    // reference copy of storage
    logic [7:0] exp_q [$];                          // bytes owed on o_tx, oldest first
    logic [7:0] mon_q [$];                          // bytes decoded from o_tx
    logic [7:0] last_exp;                           // last byte the LEDs should show
    int         letter_cnt;                         // letters sent so far

    uart_mem_top dut (
        .i_controller_clk(i_controller_clk), .i_rst(i_rst), .i_rx(i_rx),
        .o_tx(o_tx), .i_btn(i_btn), .o_led(o_led)
    );

    initial begin
        i_controller_clk = 1'b0;
        forever #4 i_controller_clk = ~i_controller_clk; // 8 ns period
    end

    // returns -1 when the byte gets no answer
    function automatic int expected_response(input logic [7:0] b);
        if (b >= 8'h61 && b <= 8'h7a) begin
            model_mem[~b] = b;                      // write lands at inverted code
            return int'(b);                         // echo of the letter
        end
        if (b >= 8'h41 && b <= 8'h5a) return int'(model_mem[~(b + 8'h20)]);
        return -1;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic drive_bit(input logic v);
        @(posedge i_controller_clk);
        #1 i_rx = v;
        repeat (CLKS - 1) @(posedge i_controller_clk); // hold for one bit period
    endtask

    task automatic send_byte(input logic [7:0] b);
        int r;
        r = expected_response(b);
        if (r >= 0) begin                           // queued before the frame, reply can be quick
            exp_q.push_back(r[7:0]);
            last_exp = r[7:0];
            letter_cnt++;
        end
        drive_bit(1'b0);                            // start
        for (int i = 0; i < 8; i++) drive_bit(b[i]); // lsb first
        drive_bit(1'b1);                            // stop
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while (exp_q.size() > 0 || mon_q.size() > 0) begin
            @(negedge i_controller_clk);
            n++;
            assert (n <= limit) else abort_run("timeout: responses still owed on o_tx");
        end
    endtask

    task automatic expect_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge i_controller_clk);
            assert (o_tx === 1'b1) else abort_run("o_tx started a frame with nothing owed");
        end
    endtask

    task automatic check_led(input logic [3:0] btn, input logic [7:0] exp);
        int n;
        n = 0;
        @(posedge i_controller_clk);
        #1 i_btn = btn;
        @(negedge i_controller_clk);
        while (o_led !== exp && n < 8) begin        // buttons pass two sync flops
            @(negedge i_controller_clk);
            n++;
        end
        assert (o_led === exp)
            else abort_run($sformatf("MISMATCH o_led expected %02h actual %02h", exp, o_led));
    endtask

    initial begin : tx_monitor
        int         idle;
        logic [7:0] b;
        idle = 0;
        forever begin
            @(negedge i_controller_clk);            // o_tx settled mid cycle
            if (o_tx !== 1'b0) begin
                idle = (exp_q.size() > 0) ? idle + 1 : 0; // count only while owed
                assert (idle <= WAIT_MAX) else abort_run("timeout waiting for a frame on o_tx");
            end else begin
                idle = 0;
                repeat (CLKS / 2 - 1) @(negedge i_controller_clk); // middle of start bit
                assert (o_tx === 1'b0) else abort_run("start bit on o_tx too short");
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS) @(negedge i_controller_clk);
                    b[i] = o_tx;
                end
                repeat (CLKS) @(negedge i_controller_clk);
                assert (o_tx === 1'b1) else abort_run("stop bit on o_tx is low");
                mon_q.push_back(b);
            end
        end
    end

    initial begin : compare_proc
        logic [7:0] got;
        logic [7:0] exp;
        forever begin
            @(negedge i_controller_clk);
            if (mon_q.size() > 0) begin
                got = mon_q.pop_front();
                assert (exp_q.size() > 0)
                    else abort_run($sformatf("o_tx sent %02h with no response owed", got));
                exp = exp_q.pop_front();
                assert (got == exp)
                    else abort_run($sformatf("MISMATCH o_tx byte expected %02h actual %02h",
                                             exp, got));
            end
        end
    end

    initial begin : main_seq
        logic [7:0] pick;
        logic [7:0] letter;
        void'($urandom(32'h18e1f3b2));
        i_rst      = 1'b0;
        i_rx       = 1'b1;                          // idle line
        i_btn      = 4'h0;
        last_exp   = 8'h00;
        letter_cnt = 0;
        for (int a = 0; a < 256; a++) model_mem[a] = 8'h00; // storage clears at reset
        repeat (8) @(posedge i_controller_clk);
        #1 i_rst = 1'b1;
        repeat (4) @(posedge i_controller_clk);

        send_byte("m");                             // write echoes the letter
        send_byte("M");                             // read back
        wait_drained(4 * FRAME);
        send_byte("Q");                             // never written, reads 00
        wait_drained(4 * FRAME);

        send_byte("7");
        send_byte("!");
        send_byte(8'h0d);
        send_byte(8'h00);
        send_byte(8'h7f);
        send_byte("@");                             // just below 'A'
        send_byte("[");                             // just above 'Z'
        send_byte(8'h60);                           // just below 'a'
        send_byte(8'h7b);                           // just above 'z'
        expect_quiet(2 * FRAME);
        send_byte("k");
        send_byte("K");
        wait_drained(4 * FRAME);

        for (int i = 0; i < NUM_RAND; i++) begin    // back to back, crosses refreshes
            pick = 8'($urandom_range(51, 0));
            if (pick < 8'd26) letter = 8'h61 + pick;
            else letter = 8'h41 + pick - 8'd26;
            send_byte(letter);
        end
        wait_drained(6 * FRAME);
        expect_quiet(2 * FRAME);

        check_led(4'h0, last_exp);                  // default view
        check_led(4'h4, letter_cnt[7:0]);           // request count view

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- verif/uart_mem_assertions.sv
`timescale 1ns/1ps
`include "bridge_config.svh"

module uart_mem_assertions (
    input logic              i_controller_clk,
    input logic              i_rst,
    input mem_pkg::mem_req_t i_req,
    input logic              i_req_stb,
    input logic              i_stall,
    input mem_pkg::mem_rsp_t i_rsp,
    input logic              i_rsp_valid,
    input logic              i_rsp_ready
);
    import mem_pkg::*;

    localparam int LAT = `BRIDGE_MEM_LATENCY;

    logic [3:0] in_flight;                          // accepted, not yet acked
    mem_op_e    op_fifo [8];                        // opcodes of accepted requests in order
    logic [2:0] wr_ptr;
    logic [2:0] rd_ptr;                             // oldest request not yet acked
    logic       accept;
    logic       fire;

    assign accept = i_req_stb && !i_stall;
    assign fire   = i_rsp_valid && i_rsp_ready;

    always_ff @(posedge i_controller_clk) begin
        if (!i_rst) begin
            in_flight <= '0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
        end else begin
            in_flight <= in_flight + {3'b000, accept} - {3'b000, fire};
            if (accept) begin
                op_fifo[wr_ptr] <= i_req.op;
                wr_ptr          <= wr_ptr + 1'b1;
            end
            if (fire) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    a_stb_no_stall: assert property (@(posedge i_controller_clk) disable iff (!i_rst)
        i_req_stb |-> !i_stall) else $error("request strobe while stall is high");

    // acks leave in accept order, so the oldest opcode must come back
    a_ack_matched: assert property (@(posedge i_controller_clk) disable iff (!i_rst)
        i_rsp_valid |-> (in_flight != 4'd0 && i_rsp.op == op_fifo[rd_ptr]))
        else $error("ack without a matching accepted request");

    // empty pipe, nothing ahead can freeze it
    a_ack_latency: assert property (@(posedge i_controller_clk) disable iff (!i_rst)
        (accept && in_flight == 4'd0) |-> ##LAT i_rsp_valid)
        else $error("ack not at fixed latency");

    a_rsp_hold: assert property (@(posedge i_controller_clk) disable iff (!i_rst)
        (i_rsp_valid && !i_rsp_ready) |=> (i_rsp_valid && $stable(i_rsp)))
        else $error("response changed under back-pressure");

endmodule

bind mem_controller uart_mem_assertions u_checks (
    .i_controller_clk(i_controller_clk), .i_rst(i_rst), .i_req(i_req),
    .i_req_stb(i_req_stb), .i_stall(o_stall), .i_rsp(o_rsp), .i_rsp_valid(o_rsp_valid),
    .i_rsp_ready(i_rsp_ready)
);
